/* alu.sv */
module alu
	import aluPkg::*;
(
	input  logic    CLK,
	input  logic    RSTb,

	input  logic    issue,
	input  aluOpT   issueCode,
	input  dataWord issueA,
	input  dataWord issueB,

	output dataWord aluOut,
	output aluFlags flags,		// C, Z and S registers.
	output aluFlags nextFlags	// Flags after the current op.
);

	function automatic logic isZero(input dataWord value);
		isZero = (value == '0);
	endfunction

	// ----------------------------------------
	// Arithmetic and logic terms
	// ----------------------------------------

	logic [DATA_BITS:0] addRes;	// Carry in the top bit.
	logic [DATA_BITS:0] subRes;	// Borrow in the top bit.
	dataWord andRes;
	dataWord orRes;
	dataWord xorRes;

	assign addRes = {1'b0, issueA} + {1'b0, issueB};
	assign subRes = {1'b0, issueA} - {1'b0, issueB};
	assign andRes = issueA & issueB;
	assign orRes  = issueA | issueB;
	assign xorRes = issueA ^ issueB;

	always_comb begin
		// Flags hold unless the op names them.
		nextFlags = flags;
		aluOut    = '0;

		case (issueCode)
			opMove: aluOut = issueA;	// Straight to write-back.
			opClrC: nextFlags[FLAG_C] = 1'b0;
			opSetC: nextFlags[FLAG_C] = 1'b1;
			opClrZ: nextFlags[FLAG_Z] = 1'b0;
			opSetZ: nextFlags[FLAG_Z] = 1'b1;
			opClrS: nextFlags[FLAG_S] = 1'b0;
			opSetS: nextFlags[FLAG_S] = 1'b1;
			opAdd: begin
				aluOut            = addRes[DATA_BITS-1:0];
				nextFlags[FLAG_C] = addRes[DATA_BITS];
				nextFlags[FLAG_Z] = isZero(addRes[DATA_BITS-1:0]);
				nextFlags[FLAG_S] = addRes[DATA_BITS-1];
			end
			opSub,
			opCmp: begin
				aluOut            = subRes[DATA_BITS-1:0];
				nextFlags[FLAG_C] = subRes[DATA_BITS];
				nextFlags[FLAG_Z] = isZero(subRes[DATA_BITS-1:0]);
				nextFlags[FLAG_S] = subRes[DATA_BITS-1];
			end
			opMul,
			opMuls: aluOut = '0;	// Reserved with no multiplier.
			opAnd,
			opTest: begin
				aluOut            = andRes;
				nextFlags[FLAG_Z] = isZero(andRes);
			end
			opOr: begin
				aluOut            = orRes;
				nextFlags[FLAG_Z] = isZero(orRes);
			end
			opXor: begin
				aluOut            = xorRes;
				nextFlags[FLAG_Z] = isZero(xorRes);
			end
		endcase
	end

	// ----------------------------------------
	// Flag registers
	// ----------------------------------------

	// Only an issued op moves the flags.
	always_ff @(posedge CLK) begin
		if (!RSTb)
			flags <= '0;
		else if (issue)
			flags <= nextFlags;
	end

endmodule

/* aluPkg.sv */
package aluPkg;

	// ----------------------------------------
	// Data path widths
	// ----------------------------------------

	localparam int DATA_BITS = 16;
	localparam int OP_BITS   = 4;
	localparam int FLAG_BITS = 3;

	// Bit positions inside the flag vector.
	localparam int FLAG_C = 2;
	localparam int FLAG_Z = 1;
	localparam int FLAG_S = 0;

	typedef logic [DATA_BITS-1:0] dataWord;	// Operand or result.
	typedef logic [FLAG_BITS-1:0] aluFlags;	// {C, Z, S}.

	// ----------------------------------------
	// Operation codes
	// ----------------------------------------

	typedef enum logic [OP_BITS-1:0] {
		opMove = 4'd0,
		opClrC = 4'd1,
		opSetC = 4'd2,
		opClrZ = 4'd3,
		opSetZ = 4'd4,
		opClrS = 4'd5,
		opSetS = 4'd6,
		opAdd  = 4'd7,
		opSub  = 4'd8,
		opMul  = 4'd9,		// Reserved.
		opMuls = 4'd10,		// Reserved.
		opCmp  = 4'd11,
		opAnd  = 4'd12,
		opOr   = 4'd13,
		opXor  = 4'd14,
		opTest = 4'd15
	} aluOpT;

endpackage

/* execUnit.f */
aluPkg.sv
flowPkg.sv
opQueue.sv
alu.sv
resultQueue.sv
execUnit.sv
execUnit_chk.sv
execUnit_tb.sv

/* execUnit.sv */
module execUnit
	import aluPkg::*;
(
	input  logic    CLK,
	input  logic    RSTb,

	// Credit-based upstream side.
	input  logic    opValid,
	input  aluOpT   opCode,
	input  dataWord opA,
	input  dataWord opB,
	output logic    opCredit,

	// Credit-based downstream side.
	output logic    resValid,
	output dataWord resData,
	output aluFlags resFlags,
	input  logic    resCredit
);

	// Issue path.
	logic    issue;
	aluOpT   issueCode;
	dataWord issueA;
	dataWord issueB;
	logic    resReady;

	// ALU results.
	dataWord aluOut;
	aluFlags nextFlags;

	opQueue uOpQueue (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.opValid   (opValid),
		.opCode    (opCode),
		.opA       (opA),
		.opB       (opB),
		.opCredit  (opCredit),
		.resReady  (resReady),
		.issue     (issue),
		.issueCode (issueCode),
		.issueA    (issueA),
		.issueB    (issueB)
	);

	alu uAlu (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.issue     (issue),
		.issueCode (issueCode),
		.issueA    (issueA),
		.issueB    (issueB),
		.aluOut    (aluOut),
		.flags     (),
		.nextFlags (nextFlags)
	);

	// Flag state is captured per result from nextFlags.
	resultQueue uResultQueue (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.issue     (issue),
		.aluOut    (aluOut),
		.nextFlags (nextFlags),
		.resReady  (resReady),
		.resValid  (resValid),
		.resData   (resData),
		.resFlags  (resFlags),
		.resCredit (resCredit)
	);

endmodule

/* execUnit_chk.sv */
module execUnit_chk
	import flowPkg::*;
(
	input logic       CLK,
	input logic       RSTb,
	input logic       wrEn,			// Entry written this cycle.
	input logic       full,
	input logic       sendValid,
	input creditCount credit,
	input creditCount maxCredit
);

	timeunit 1ns;
	timeprecision 1ps;

	// Counter never passes its limit.
	creditLimit: assert property (@(posedge CLK) disable iff (!RSTb)
		credit <= maxCredit)
		else $error("Credit count above %0d", maxCredit);

	noWriteWhenFull: assert property (@(posedge CLK) disable iff (!RSTb)
		!(wrEn && full))
		else $error("Write into a full queue");

	noSendWithoutCredit: assert property (@(posedge CLK) disable iff (!RSTb)
		sendValid |-> (credit != '0))
		else $error("Valid sent with no credit");

endmodule

bind resultQueue execUnit_chk resChk (.CLK(CLK), .RSTb(RSTb),
	.wrEn(issue), .full(!resReady), .sendValid(resValid), .credit(credit),
	.maxCredit(creditCount'(RES_CREDITS)));

// Upstream credits match the free op queue slots.
bind opQueue execUnit_chk opChk (.CLK(CLK), .RSTb(RSTb),
	.wrEn(push), .full(count == queueCount'(OPQ_DEPTH)), .sendValid(opValid),
	.credit(creditCount'(OPQ_DEPTH) - count), .maxCredit(creditCount'(OPQ_DEPTH)));

/* execUnit_tb.sv */
module execUnit_tb
	import aluPkg::*;
	import flowPkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int TABLE_LEN      = 24;
	localparam int TIMEOUT_CYCLES = TABLE_LEN * 20;
	localparam int MAX_RET_DELAY  = 8;	// Consumer hold time in cycles.

	logic    CLK       = 1'b0;
	logic    RSTb      = 1'b0;
	logic    opValid   = 1'b0;
	aluOpT   opCode    = opMove;
	dataWord opA       = '0;
	dataWord opB       = '0;
	logic    resCredit = 1'b0;
	logic    opCredit;
	logic    resValid;
	dataWord resData;
	aluFlags resFlags;

	// Stimulus table with expected flags as {C, Z, S}.
	aluOpT   codeTab [TABLE_LEN];
	dataWord aTab    [TABLE_LEN];
	dataWord bTab    [TABLE_LEN];
	dataWord dataTab [TABLE_LEN];
	aluFlags flagTab [TABLE_LEN];
	int      fillIdx = 0;

	int upCredits    = OPQ_DEPTH;	// Sender side view.
	int sendIdx      = 0;
	int recvIdx      = 0;
	int creditPulses = 0;
	int heldResults  = 0;		// Results in the consumer buffer.
	int dueCycles [$];
	int lastDue      = 0;
	int cycle        = 0;
	int seed         = 75037;
	int dataErrors   = 0;
	int flagErrors   = 0;
	int flowErrors   = 0;

	execUnit UUT (.CLK(CLK), .RSTb(RSTb), .opValid(opValid), .opCode(opCode), .opA(opA),
		.opB(opB), .opCredit(opCredit), .resValid(resValid), .resData(resData),
		.resFlags(resFlags), .resCredit(resCredit));

	always #2 CLK = ~CLK;

	task automatic addEntry(input aluOpT code, input dataWord a, input dataWord b,
		input dataWord expData, input aluFlags expFlags);
		codeTab[fillIdx] = code;
		aTab[fillIdx]    = a;
		bTab[fillIdx]    = b;
		dataTab[fillIdx] = expData;
		flagTab[fillIdx] = expFlags;
		fillIdx++;
	endtask

	// Each row starts from the flags left by the row above.
	task automatic loadTable();
		addEntry(opSetZ, 16'h1234, 16'h0000, 16'h0000, 3'b010);
		addEntry(opAdd,  16'h0001, 16'h0002, 16'h0003, 3'b000);
		addEntry(opAdd,  16'hFFFF, 16'h0001, 16'h0000, 3'b110);	// Carry out and zero.
		addEntry(opAdd,  16'h7FFF, 16'h0001, 16'h8000, 3'b001);
		addEntry(opSub,  16'h0005, 16'h0003, 16'h0002, 3'b000);
		addEntry(opSub,  16'h0003, 16'h0005, 16'hFFFE, 3'b101);	// Borrow.
		addEntry(opAnd,  16'h00F0, 16'h0F00, 16'h0000, 3'b111);
		addEntry(opOr,   16'h00F0, 16'h0F00, 16'h0FF0, 3'b101);
		addEntry(opXor,  16'hAAAA, 16'hAAAA, 16'h0000, 3'b111);
		addEntry(opTest, 16'h8001, 16'h0001, 16'h0001, 3'b101);
		addEntry(opMul,  16'h0003, 16'h0004, 16'h0000, 3'b101);
		addEntry(opMuls, 16'hFFFF, 16'h0002, 16'h0000, 3'b101);
		addEntry(opClrC, 16'h5555, 16'hAAAA, 16'h0000, 3'b001);
		addEntry(opClrS, 16'h5555, 16'hAAAA, 16'h0000, 3'b000);
		addEntry(opSetC, 16'h5555, 16'hAAAA, 16'h0000, 3'b100);
		addEntry(opSetS, 16'h5555, 16'hAAAA, 16'h0000, 3'b101);
		addEntry(opMove, 16'hBEEF, 16'h1111, 16'hBEEF, 3'b101);
		addEntry(opCmp,  16'h1234, 16'h1234, 16'h0000, 3'b010);
		addEntry(opClrZ, 16'h5555, 16'hAAAA, 16'h0000, 3'b000);
		addEntry(opCmp,  16'h0010, 16'h0020, 16'hFFF0, 3'b101);
		addEntry(opAdd,  16'h8000, 16'h8000, 16'h0000, 3'b110);
		addEntry(opOr,   16'h0000, 16'h0000, 16'h0000, 3'b110);
		addEntry(opXor,  16'h1234, 16'h00FF, 16'h12CB, 3'b100);
		addEntry(opSub,  16'h8000, 16'h0001, 16'h7FFF, 3'b000);
	endtask

	task automatic checkData(input dataWord actual, input dataWord expected, input int entry);
		if (actual !== expected) begin
			$display("MISMATCH at %0t: resData got %h, expected %h (entry %0d)",
				$time, actual, expected, entry);
			dataErrors++;
		end
	endtask

	task automatic checkFlags(input aluFlags actual, input aluFlags expected, input int entry);
		if (actual !== expected) begin
			$display("MISMATCH at %0t: resFlags got %b, expected %b (entry %0d)",
				$time, actual, expected, entry);
			flagErrors++;
		end
	endtask

	// ----------------------------------------
	// One clock cycle of sender and consumer
	// ----------------------------------------

	task automatic runCycle();
		int delay;
		@(posedge CLK);
		#1;
		opValid   = 1'b0;
		resCredit = 1'b0;
		if (sendIdx < TABLE_LEN && upCredits > 0) begin
			opValid = 1'b1;
			opCode  = codeTab[sendIdx];
			opA     = aTab[sendIdx];
			opB     = bTab[sendIdx];
			upCredits--;
			sendIdx++;
		end
		if (dueCycles.size() > 0 && dueCycles[0] <= cycle) begin
			void'(dueCycles.pop_front());
			resCredit = 1'b1;	// Frees one slot.
			heldResults--;
		end
		@(negedge CLK);
		if (opCredit) begin
			upCredits++;
			creditPulses++;
		end
		if (resValid) begin
			if (heldResults >= RES_CREDITS) begin
				$display("ERROR at %0t: result sent while the consumer buffer is full", $time);
				flowErrors++;
			end
			if (recvIdx >= TABLE_LEN) begin
				$display("ERROR at %0t: more results than operations sent", $time);
				flowErrors++;
			end else begin
				checkData(resData, dataTab[recvIdx], recvIdx);
				checkFlags(resFlags, flagTab[recvIdx], recvIdx);
			end
			recvIdx++;
			heldResults++;
			delay   = $unsigned($random(seed)) % MAX_RET_DELAY;
			lastDue = (lastDue + 1 > cycle + 1 + delay) ? lastDue + 1 : cycle + 1 + delay;
			dueCycles.push_back(lastDue);
		end
	endtask

	task automatic finishRun(input bit timedOut);
		$display("Errors: data %0d, flags %0d, flow %0d", dataErrors, flagErrors, flowErrors);
		if (!timedOut && dataErrors + flagErrors + flowErrors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	endtask

	initial begin
		loadTable();
		repeat (2) @(posedge CLK);
		#1;
		RSTb = 1'b1;
		@(negedge CLK);
		if (resValid !== 1'b0 || opCredit !== 1'b0) begin
			$display("ERROR at %0t: resValid or opCredit high right after reset", $time);
			flowErrors++;
		end
		while (recvIdx < TABLE_LEN)
			runCycle();
		repeat (8)
			runCycle();	// Quiet tail to catch extra results.
		if (creditPulses != TABLE_LEN) begin
			$display("ERROR: %0d opCredit pulses for %0d operations", creditPulses, TABLE_LEN);
			flowErrors++;
		end
		finishRun(1'b0);
	end

	// Run limit.
	initial begin
		while (cycle < TIMEOUT_CYCLES) begin
			@(posedge CLK);
			cycle++;
		end
		$display("ERROR: run stopped after %0d cycles, only %0d of %0d results seen",
			TIMEOUT_CYCLES, recvIdx, TABLE_LEN);
		finishRun(1'b1);
	end

endmodule

/* flowPkg.sv */
package flowPkg;

	// Queue sizes and credit limits.
	localparam int OPQ_DEPTH   = 4;	// Also the number of upstream credits.
	localparam int RESQ_DEPTH  = 4;
	localparam int RES_CREDITS = 4;	// Downstream buffer size.

	localparam int PTR_BITS = 2;
	localparam int CNT_BITS = 3;

	// Index into a 4-entry queue.
	typedef logic [PTR_BITS-1:0] queuePtr;

	// Holds 0 to 4.
	typedef logic [CNT_BITS-1:0] creditCount;

	// Occupancy of a queue, 0 to 4.
	typedef logic [CNT_BITS-1:0] queueCount;

endpackage

/* opQueue.sv */
module opQueue
	import aluPkg::*;
	import flowPkg::*;
(
	input  logic    CLK,
	input  logic    RSTb,

	// Issuing front end.
	input  logic    opValid,
	input  aluOpT   opCode,
	input  dataWord opA,
	input  dataWord opB,
	output logic    opCredit,

	// Result queue has room.
	input  logic    resReady,

	// Towards ALU and result queue.
	output logic    issue,
	output aluOpT   issueCode,
	output dataWord issueA,
	output dataWord issueB
);

	// ----------------------------------------
	// Storage
	// ----------------------------------------

	aluOpT   codeMem [OPQ_DEPTH];
	dataWord aMem    [OPQ_DEPTH];
	dataWord bMem    [OPQ_DEPTH];

	queuePtr   wrPtr;
	queuePtr   rdPtr;
	queueCount count;

	logic push;
	logic pop;

	// Sender only drives opValid while it holds a credit.
	assign push = opValid;
	assign pop  = (count != '0) && resReady;

	always_ff @(posedge CLK) begin
		if (push) begin
			codeMem[wrPtr] <= opCode;
			aMem[wrPtr]    <= opA;
			bMem[wrPtr]    <= opB;
		end
	end

	// ----------------------------------------
	// Pointers and occupancy
	// ----------------------------------------

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push)
				wrPtr <= wrPtr + 1'b1;	// Wraps at depth 4.
			if (pop)
				rdPtr <= rdPtr + 1'b1;

			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// Idle or both.
			endcase
		end
	end

	// Head of the queue goes out in order.
	assign issue     = pop;
	assign issueCode = codeMem[rdPtr];
	assign issueA    = aMem[rdPtr];
	assign issueB    = bMem[rdPtr];

	// Each issued entry frees one slot upstream.
	assign opCredit = pop;

endmodule

/* resultQueue.sv */
module resultQueue
	import aluPkg::*;
	import flowPkg::*;
(
	input  logic    CLK,
	input  logic    RSTb,

	// From the ALU in the issue cycle.
	input  logic    issue,
	input  dataWord aluOut,
	input  aluFlags nextFlags,
	output logic    resReady,	// Not full.

	// Write-back consumer.
	output logic    resValid,
	output dataWord resData,
	output aluFlags resFlags,
	input  logic    resCredit
);

	// ----------------------------------------
	// Storage
	// ----------------------------------------

	dataWord dataMem [RESQ_DEPTH];
	aluFlags flagMem [RESQ_DEPTH];

	queuePtr    wrPtr;
	queuePtr    rdPtr;
	queueCount  count;
	creditCount credit;	// Free slots downstream.

	logic send;

	// Result and flag state travel together.
	always_ff @(posedge CLK) begin
		if (issue) begin
			dataMem[wrPtr] <= aluOut;
			flagMem[wrPtr] <= nextFlags;
		end
	end

	assign resReady = (count != queueCount'(RESQ_DEPTH));

	// Head goes out whenever the consumer has room.
	assign send = (count != '0) && (credit != '0);

	// ----------------------------------------
	// Pointers and occupancy
	// ----------------------------------------

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (issue)
				wrPtr <= wrPtr + 1'b1;
			if (send)
				rdPtr <= rdPtr + 1'b1;

			case ({issue, send})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// ----------------------------------------
	// Downstream credits
	// ----------------------------------------

	always_ff @(posedge CLK) begin
		if (!RSTb)
			credit <= creditCount'(RES_CREDITS);	// Consumer buffer starts empty.
		else begin
			case ({send, resCredit})
				2'b10:   credit <= credit - 1'b1;
				2'b01:   credit <= credit + 1'b1;
				default: credit <= credit;	// Spend and return cancel.
			endcase
		end
	end

	assign resValid = send;
	assign resData  = dataMem[rdPtr];
	assign resFlags = flagMem[rdPtr];

endmodule

/* run.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -f execUnit.f \
	--top-module execUnit_tb -o simExec

out=$(./obj_dir/simExec)
echo "$out"
echo "$out" | grep -qx "Finished with no errors"
